//--- hw/char_pkg.sv
// Character layer shared constants
package char_pkg;

    // CPU side of the tile map
    localparam int VRAM_AW = 11;            // Top bit picks the attribute byte

    // Graphics ROM
    localparam int ROM_AW = 13;             // Tile code then 3-bit row
    localparam int CODE_W = 10;             // Two attribute bits above the code byte

    // Colour path
    localparam int PAL_W = 4;
    localparam int PXL_W = 4;               // Colour PROM data width

    // H phase at which the ROM address goes out
    localparam logic [2:0] DATAREAD = 3'd1;

    // H[2:1] value reserved for the CPU
    localparam logic [1:0] CPU_SLOT = 2'd3;

    // Attribute byte layout
    // 7:6 are upper code bits and 3:0 the palette
    localparam int ATTR_HFLIP = 4;
    localparam int ATTR_VFLIP = 5;

endpackage

//--- hw/char_if.sv
// Character pipeline stage links
`timescale 1ns/10ps

// Decoded map entry for the next tile
interface char_tile_if;
    import char_pkg::*;

    logic [CODE_W-1:0] code;
    logic [PAL_W-1:0]  pal;
    logic              hflip;   // Already toggled by screen flip
    logic              vflip;
    logic [2:0]        row;     // Line inside the tile

    modport src (output code, pal, hflip, vflip, row);
    modport dst (input  code, pal, hflip, vflip, row);
endinterface

// ROM row handed to the pixel shifter
interface char_row_if;
    import char_pkg::*;

    logic [15:0]      data;
    logic             hflip;
    logic [PAL_W-1:0] pal;
    logic             load;     // One pxl_cen period per tile

    modport src (output data, hflip, pal, load);
    modport dst (input  data, hflip, pal, load);
endinterface

//--- hw/char_vram.sv
// Character tile map RAM
`timescale 1ns/10ps

module char_vram #(
    parameter logic [7:0] HOFFSET = 8'd0       // Pixel offset added to H
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pxl_cen,
    input  logic [7:0]                   h,
    input  logic [7:0]                   v,
    input  logic                         flip,      // Whole screen flip
    input  logic [char_pkg::VRAM_AW-1:0] ab,
    input  logic [7:0]                   din,
    input  logic                         char_cs,
    input  logic                         wr_n,
    output logic [7:0]                   dout,
    output logic                         busy,
    char_tile_if.src                     tile
);
    import char_pkg::*;

    localparam int EW = VRAM_AW - 1;            // Entry index width

    logic [7:0]    map_lo [2**EW];              // Code bytes
    logic [7:0]    map_hi [2**EW];              // Attribute bytes
    logic [7:0]    hfix;
    logic          cpu_slot;
    logic [EW-1:0] cpu_idx;
    logic [4:0]    scan_col;
    logic [EW-1:0] scan_idx;
    logic [7:0]    code_lo;                     // Entry of the next tile
    logic [7:0]    attr;

    assign hfix     = h + HOFFSET;
    assign cpu_slot = h[2:1] == CPU_SLOT;       // Two phases of every tile
    assign busy     = char_cs && !cpu_slot;     // CPU must hold its request
    assign cpu_idx  = ab[EW-1:0];

    // One tile ahead of the beam
    assign scan_col = hfix[7:3] + 5'd1;
    assign scan_idx = {v[7:3], scan_col};       // 32 tiles per row

    // CPU port
    // Runs on every clock of the slot, a held write just repeats
    always_ff @(posedge clk) begin
        if (char_cs && cpu_slot) begin
            if (ab[VRAM_AW-1]) begin
                if (!wr_n) map_hi[cpu_idx] <= din;
                dout <= map_hi[cpu_idx];
            end else begin
                if (!wr_n) map_lo[cpu_idx] <= din;
                dout <= map_lo[cpu_idx];
            end
        end
    end

    // Scan read at phase 0, entry valid from phase 1
    // Last tile of a line still sees the old V so column 0 lags one line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_lo <= '0;
            attr    <= '0;
        end else if (pxl_cen && hfix[2:0] == 3'd0) begin
            code_lo <= map_lo[scan_idx];
            attr    <= map_hi[scan_idx];
        end
    end

    // Entry decode
    assign tile.code  = {attr[7:6], code_lo};
    assign tile.pal   = attr[PAL_W-1:0];
    assign tile.hflip = attr[ATTR_HFLIP] ^ flip;   // Screen flip toggles per tile
    assign tile.vflip = attr[ATTR_VFLIP] ^ flip;
    assign tile.row   = v[2:0];

endmodule

//--- hw/char_fetch.sv
// Character ROM address and row latch
`timescale 1ns/10ps

module char_fetch #(
    parameter logic [7:0] HOFFSET = 8'd0       // Pixel offset added to H
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic [7:0]                  h,
    char_tile_if.dst                    tile,
    output logic [char_pkg::ROM_AW-1:0] char_addr,
    input  logic [15:0]                 rom_data,
    input  logic                        rom_ok,     // Level, high when rom_data matches
    char_row_if.src                     row
);
    import char_pkg::*;

    logic [7:0]       hfix;
    logic [2:0]       phase;
    logic             rom_win;
    logic [15:0]      good_data;                // Last valid ROM row
    logic             hflip_q;
    logic [PAL_W-1:0] pal_q;

    assign hfix  = h + HOFFSET;
    assign phase = hfix[2:0];

    // Phases 3 to 6 only
    // Data before that may still belong to the previous address
    assign rom_win = phase > DATAREAD + 3'd1 && phase != 3'd7;

    // ROM address with vertical flip on the row bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            char_addr <= '0;
        end else if (pxl_cen && phase == DATAREAD) begin
            char_addr <= {tile.code, tile.row ^ {3{tile.vflip}}};
        end
    end

    // Attributes travel along with the address
    always_ff @(posedge clk) begin
        if (pxl_cen && phase == DATAREAD) begin
            hflip_q <= tile.hflip;
            pal_q   <= tile.pal;
        end
    end

    // Checked on every clock, rom_ok may rise between pxl_cen pulses
    always_ff @(posedge clk) begin
        if (rom_win && rom_ok) good_data <= rom_data;
    end

    // Hand over at phase 7 so the shifter starts on phase 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row.load <= 1'b0;
        end else if (pxl_cen) begin
            row.load <= phase == 3'd7;          // Lasts one pxl_cen period
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen && phase == 3'd7) begin
            row.data  <= good_data;             // Old row kept if rom_ok never came
            row.hflip <= hflip_q;
            row.pal   <= pal_q;
        end
    end

endmodule

//--- hw/char_shift.sv
// Character pixel shifter
`timescale 1ns/10ps

module char_shift #(
    parameter logic [7:0] HOFFSET = 8'd0       // Pixel offset added to H
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic [7:0]                 h,
    char_row_if.dst                    row,
    output logic [char_pkg::PAL_W-1:0] pal,
    output logic [1:0]                 col
);

    logic [7:0] hfix;
    logic [7:0] cur;        // Byte on screen, plane 1 in 7:4 and plane 0 in 3:0
    logic [7:0] nxt;        // Second half of the row
    logic [7:0] first_b;
    logic [7:0] second_b;
    logic [7:0] src;
    logic [1:0] pix;
    logic [7:0] shifted;

    assign hfix = h + HOFFSET;

    // Flipped rows start from the last pixel of byte 1
    assign first_b  = row.hflip ? row.data[15:8] : row.data[7:0];
    assign second_b = row.hflip ? row.data[7:0]  : row.data[15:8];

    always_comb begin
        if (row.load) begin
            src = first_b;                      // Pixel 0 goes out straight from the row
        end else if (hfix[2:0] == 3'd4) begin
            src = nxt;                          // Four pixels done
        end else begin
            src = cur;
        end
        // Plane 1 bit above plane 0 bit
        pix = row.hflip ? {src[4], src[0]} : {src[7], src[3]};
        // Both nibbles move together
        shifted = row.hflip ? {1'b0, src[7:5], 1'b0, src[3:1]}
                            : {src[6:4], 1'b0, src[2:0], 1'b0};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur <= '0;
            nxt <= '0;
            col <= '0;
            pal <= '0;
        end else if (pxl_cen) begin
            cur <= shifted;
            if (row.load) nxt <= second_b;
            col <= pix;
            pal <= row.pal;                     // Level for the whole tile so one stage matches
        end
    end

endmodule

//--- hw/char_palette.sv
// Character colour PROM
`timescale 1ns/10ps

module char_palette (
    input  logic                       clk,
    input  logic                       pxl_cen,
    input  logic [char_pkg::PAL_W-1:0] pal,
    input  logic [1:0]                 col,
    input  logic [7:0]                 prog_addr,
    input  logic [char_pkg::PXL_W-1:0] prog_din,
    input  logic                       prom_we,
    input  logic                       char_on,   // Low blanks the layer
    output logic [char_pkg::PXL_W-1:0] char_pxl
);
    import char_pkg::*;

    localparam int FILL = 8 - PAL_W - 2;        // Unused upper address bits

    logic [PXL_W-1:0] prom [256];
    logic [7:0]       rd_addr;
    logic [PXL_W-1:0] prom_q = '0;              // Zero until the first lookup

    assign rd_addr = {{FILL{1'b0}}, pal, col};

    // Programming port works at any clock
    always_ff @(posedge clk) begin
        if (prom_we) prom[prog_addr] <= prog_din;
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) prom_q <= prom[rd_addr];
    end

    // All ones means transparent for the mixer
    assign char_pxl = char_on ? prom_q : '1;

endmodule

//--- hw/char_top.sv
// Character layer top level
`timescale 1ns/10ps

module char_top #(
    parameter logic [7:0] HOFFSET = 8'd0       // Pixel offset added to H
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pxl_cen,
    input  logic [7:0]                   h,
    input  logic [7:0]                   v,
    input  logic                         flip,
    input  logic [char_pkg::VRAM_AW-1:0] ab,
    input  logic [7:0]                   din,
    output logic [7:0]                   dout,
    input  logic                         char_cs,
    input  logic                         wr_n,
    output logic                         busy,
    input  logic [7:0]                   prog_addr,
    input  logic [char_pkg::PXL_W-1:0]   prog_din,
    input  logic                         prom_we,
    output logic [char_pkg::ROM_AW-1:0]  char_addr,
    input  logic [15:0]                  rom_data,
    input  logic                         rom_ok,
    input  logic                         char_on,
    output logic [char_pkg::PXL_W-1:0]   char_pxl
);
    import char_pkg::*;

    char_tile_if tile_bus ();                   // Map entry to fetch
    char_row_if  row_bus ();                    // ROM row to shifter

    logic [PAL_W-1:0] shift_pal;
    logic [1:0]       shift_col;

    char_vram #(.HOFFSET(HOFFSET)) u_vram (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .h       (h),
        .v       (v),
        .flip    (flip),
        .ab      (ab),
        .din     (din),
        .char_cs (char_cs),
        .wr_n    (wr_n),
        .dout    (dout),
        .busy    (busy),
        .tile    (tile_bus.src)
    );

    char_fetch #(.HOFFSET(HOFFSET)) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .h         (h),
        .tile      (tile_bus.dst),
        .char_addr (char_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .row       (row_bus.src)
    );

    char_shift #(.HOFFSET(HOFFSET)) u_shift (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .h       (h),
        .row     (row_bus.dst),
        .pal     (shift_pal),
        .col     (shift_col)
    );

    char_palette u_palette (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .pal       (shift_pal),
        .col       (shift_col),
        .prog_addr (prog_addr),
        .prog_din  (prog_din),
        .prom_we   (prom_we),
        .char_on   (char_on),
        .char_pxl  (char_pxl)
    );

endmodule

//--- sim/char_tb.sv
// Character layer testbench
`timescale 1ns/10ps

module char_tb;
    import char_pkg::*;

    localparam int TEST_FRAMES = 6;                 // At most one frame per test
    localparam int FRAME_CLKS  = 256 * 256 * 2;     // 256 lines of 256 pxl_cen pairs
    localparam int MARGIN_CLKS = 20000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               pxl_cen = 1'b0;
    logic [7:0]         h = '0;
    logic [7:0]         v = '0;
    logic               flip;
    logic [VRAM_AW-1:0] ab;
    logic [7:0]         din;
    logic [7:0]         dout;
    logic               char_cs;
    logic               wr_n;
    logic               busy;
    logic [7:0]         prog_addr;
    logic [PXL_W-1:0]   prog_din;
    logic               prom_we;
    logic [ROM_AW-1:0]  char_addr;
    logic [15:0]        rom_data = '0;
    logic               rom_ok = 1'b0;
    logic               char_on;
    logic [PXL_W-1:0]   char_pxl;

    logic               video_en;               // Starts H and V after reset checks
    logic [ROM_AW-1:0]  rom_addr_q = '0;
    logic [1:0]         rom_wait = '0;
    logic [7:0]         map_lo_ref [1024];      // Map as written by the CPU
    logic [7:0]         map_hi_ref [1024];
    logic [PXL_W-1:0]   prom_ref [256];
    logic               busy_seen;
    int                 seed = 9937;
    int                 byte_errs = 0;
    int                 pxl_errs = 0;
    int                 addr_errs = 0;
    int                 other_errs = 0;

    char_top #(.HOFFSET(8'd0)) UUT (.*);

    always #5 clk = ~clk;

    // Pixel enable every other clock and the H and V counters
    always @(posedge clk) begin
        if (video_en) begin
            pxl_cen <= !pxl_cen;
            if (pxl_cen) begin
                h <= h + 8'd1;
                if (h == 8'hff) v <= v + 8'd1;
            end
        end
    end

    // Graphics ROM contents from an odd multiplier over every address
    function automatic logic [15:0] rom_word(input logic [ROM_AW-1:0] addr);
        logic [15:0] a;
        a = {3'b000, addr};
        return (a * 16'd40503) ^ 16'h6c3a;
    endfunction

    // ROM answers 0 to 2 clocks late with junk on the bus meanwhile
    always @(posedge clk) begin
        if (char_addr != rom_addr_q) begin
            rom_addr_q <= char_addr;
            rom_wait   <= 2'($unsigned($random(seed)) % 3);
            rom_ok     <= 1'b0;
            rom_data   <= ~rom_word(char_addr);
        end else if (rom_wait != 2'd0) begin
            rom_wait <= rom_wait - 2'd1;
        end else begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(char_addr);
        end
    end

    // ROM address of the tile in map column col for line lv
    function automatic logic [ROM_AW-1:0] tile_addr(input logic [7:0] lv, input logic [4:0] col);
        logic [9:0] idx;
        logic [7:0] hi;
        idx = {lv[7:3], col};
        hi  = map_hi_ref[idx];
        return {hi[7:6], map_lo_ref[idx], lv[2:0] ^ {3{hi[ATTR_VFLIP] ^ flip}}};
    endfunction

    // Expected pixel of screen column x on a line
    function automatic logic [PXL_W-1:0] ref_pxl(input logic [7:0] line, input logic [7:0] x);
        logic [7:0]  lv;
        logic [9:0]  idx;
        logic [7:0]  hi;
        logic        hf;
        logic [2:0]  p;
        logic [15:0] w;
        logic [7:0]  b;
        logic [2:0]  bit_hi;
        logic [1:0]  c;
        lv  = (x < 8'd8) ? line - 8'd1 : line;     // Column 0 fetched on the line before
        idx = {lv[7:3], x[7:3]};
        hi  = map_hi_ref[idx];
        hf  = hi[ATTR_HFLIP] ^ flip;
        w   = rom_word(tile_addr(lv, x[7:3]));
        p   = hf ? 3'd7 - x[2:0] : x[2:0];          // Pixel index inside the ROM row
        b   = p[2] ? w[15:8] : w[7:0];
        bit_hi = 3'd7 - {1'b0, p[1:0]};
        c   = {b[bit_hi], b[bit_hi - 3'd4]};        // Plane 1 then plane 0
        return char_on ? prom_ref[{2'b00, hi[3:0], c}] : '1;
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp,
                              input logic [VRAM_AW-1:0] addr);
        if (got !== exp) begin
            byte_errs++;
            $display("Mismatch at %0t: read of %h gave %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_pxl(input logic [PXL_W-1:0] got, input logic [PXL_W-1:0] exp,
                             input logic [7:0] line, input logic [7:0] x);
        if (got !== exp) begin
            pxl_errs++;
            $display("Mismatch at %0t: line %0d column %0d gave %h, expected %h",
                     $time, line, x, got, exp);
        end
    endtask

    task automatic check_addr(input logic [ROM_AW-1:0] got, input logic [ROM_AW-1:0] exp,
                              input logic [7:0] line, input logic [7:0] x);
        if (got !== exp) begin
            addr_errs++;
            $display("Mismatch at %0t: ROM address at line %0d column %0d gave %h, expected %h",
                     $time, line, x, got, exp);
        end
    endtask

    // Holds the request until the CPU slot takes it
    task automatic cpu_access(input logic [VRAM_AW-1:0] addr, input logic write,
                              input logic [7:0] data);
        @(posedge clk);
        char_cs <= 1'b1;
        ab      <= addr;
        wr_n    <= !write;
        din     <= data;
        do begin
            @(posedge clk);
            if (busy) busy_seen = 1'b1;
            if (busy == (h[2:1] == CPU_SLOT)) begin
                other_errs++;
                $display("busy does not follow the CPU slot at %0t", $time);
            end
        end while (busy);
        char_cs <= 1'b0;
        wr_n    <= 1'b1;
    endtask

    task automatic check_reset();
        @(negedge clk);
        if (busy !== 1'b0) begin
            other_errs++;
            $display("busy is high after reset with char_cs low");
        end
        check_pxl(char_pxl, '0, 8'd0, 8'd0);   // Nothing looked up yet
        check_addr(char_addr, '0, 8'd0, 8'd0);
    endtask

    task automatic test_cpu();
        logic [9:0] idx [8];
        busy_seen = 1'b0;
        for (int i = 0; i < 8; i++) begin
            idx[i] = 10'($random(seed));
            map_lo_ref[idx[i]] = 8'($random(seed));
            map_hi_ref[idx[i]] = 8'($random(seed));
            cpu_access({1'b0, idx[i]}, 1'b1, map_lo_ref[idx[i]]);
            cpu_access({1'b1, idx[i]}, 1'b1, map_hi_ref[idx[i]]);
        end
        for (int i = 0; i < 8; i++) begin
            cpu_access({1'b0, idx[i]}, 1'b0, 8'h00);
            @(negedge clk);
            check_byte(dout, map_lo_ref[idx[i]], {1'b0, idx[i]});
            cpu_access({1'b1, idx[i]}, 1'b0, 8'h00);
            @(negedge clk);
            check_byte(dout, map_hi_ref[idx[i]], {1'b1, idx[i]});
        end
        if (!busy_seen) begin
            other_errs++;
            $display("busy never went high during CPU access");
        end
    endtask

    task automatic program_prom();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            prom_we   <= 1'b1;
            prog_addr <= 8'(a);
            prog_din  <= prom_ref[8'(a)];
        end
        @(posedge clk);
        prom_we <= 1'b0;
    endtask

    // Random tiles for one tile row with flip bits cleared unless asked for
    task automatic fill_row(input logic [4:0] r, input logic flips);
        logic [9:0] idx;
        logic [7:0] hi;
        for (int c = 0; c < 32; c++) begin
            idx = {r, 5'(c)};
            hi  = 8'($random(seed));
            if (!flips) hi[ATTR_VFLIP:ATTR_HFLIP] = 2'b00;
            map_lo_ref[idx] = 8'($random(seed));
            map_hi_ref[idx] = hi;
            cpu_access({1'b0, idx}, 1'b1, map_lo_ref[idx]);
            cpu_access({1'b1, idx}, 1'b1, hi);
        end
    endtask

    // Pixel x shows while H is x+2 so the last two spill into the next line
    task automatic check_line(input logic [7:0] line);
        logic [7:0] x;
        while (!(v == line && h == 8'd2)) @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            x = 8'(i);
            while (h != x + 8'd2) @(negedge clk);
            check_pxl(char_pxl, ref_pxl(line, x), line, x);
            if (x[2:0] == 3'd1) begin
                // H phase 3 holds the address of the next tile
                check_addr(char_addr, tile_addr(line, x[7:3] + 5'd1), line, x);
            end
        end
    endtask

    task automatic test_line(input logic flips);
        logic [4:0] r;
        r = v[7:3] + 5'd2;                          // Two tile rows ahead of the beam
        fill_row(r, flips);
        check_line({r, 3'd3});
    endtask

    // Watchdog
    initial begin
        #((TEST_FRAMES * FRAME_CLKS + MARGIN_CLKS) * 10);
        $display("Timeout: the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        video_en  = 1'b0;
        flip      = 1'b0;
        ab        = '0;
        din       = '0;
        char_cs   = 1'b0;
        wr_n      = 1'b1;
        prog_addr = '0;
        prog_din  = '0;
        prom_we   = 1'b0;
        char_on   = 1'b1;
        for (int a = 0; a < 256; a++) prom_ref[8'(a)] = PXL_W'(a * 7 + a / 16);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_reset();
        video_en <= 1'b1;
        test_cpu();
        program_prom();
        test_line(1'b0);                            // Plain tiles
        test_line(1'b1);                            // Per-tile flips
        @(posedge clk);
        flip <= 1'b1;
        test_line(1'b1);                            // Screen flip on top
        @(posedge clk);
        char_on <= 1'b0;
        test_line(1'b1);                            // Blanked layer
        @(posedge clk);
        char_on <= 1'b1;
        test_line(1'b1);
        $display("Errors: byte %0d, pixel %0d, address %0d, other %0d",
                 byte_errs, pxl_errs, addr_errs, other_errs);
        if (byte_errs + pxl_errs + addr_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/char_pkg.sv
hw/char_if.sv
hw/char_vram.sv
hw/char_fetch.sv
hw/char_shift.sv
hw/char_palette.sv
hw/char_top.sv
sim/char_tb.sv

//--- Makefile
# Character layer simulation with Verilator

LOG = sim.log

all: run

compile:
	verilator --binary --timing -j 0 --top-module char_tb -f compile.f

# Pass only when the log holds the pass line
run: compile
	./obj_dir/Vchar_tb | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean
